//--- hw/hl_proto_pkg.sv
// host frame format: sync constants, frame geometry
// command field types and stream item types
package hl_proto_pkg;

  // ------------------------------------------------------------------------
  // frame layout
  // ------------------------------------------------------------------------

  // word 0 of every frame
  localparam logic [15:0] SYNC_WORD = 16'h7F7F;
  // high byte of word 1, low byte carries the C&C header
  localparam logic [7:0]  SYNC_BYTE = 8'h7F;

  // header is sync, C&C, data high, data low
  localparam int FRAME_WORDS   = 256;
  localparam int HEADER_WORDS  = 4;
  localparam int PAYLOAD_WORDS = FRAME_WORDS - HEADER_WORDS;

  // ------------------------------------------------------------------------
  // command fields
  // ------------------------------------------------------------------------

  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;

  // base registers handled locally
  localparam cmd_addr_t ADDR_RX_CTRL = 6'h00;
  localparam cmd_addr_t ADDR_PA_CTRL = 6'h09;

  // ------------------------------------------------------------------------
  // stream items
  // ------------------------------------------------------------------------

  // tx sample, q set for the Q half of a pair
  typedef struct packed {
    logic        q;
    logic [15:0] sample;
  } iq_item_t;

  // command echo returned to the host
  typedef struct packed {
    cmd_addr_t addr;
    cmd_data_t data;
  } resp_item_t;

endpackage

//--- hw/hl_radio_pkg.sv
// base register field positions
// and the radio state handed to tx keying
package hl_radio_pkg;

  // address 0, number of rx streams minus one
  localparam int LAST_CHAN_LSB = 3;
  typedef logic [4:0] last_chan_t;

  // address 9 bit positions
  localparam int VNA_BIT    = 23;
  localparam int PA_EN_BIT  = 19;
  localparam int TR_DIS_BIT = 18;

  // register state seen by keying and the top level
  typedef struct packed {
    logic       mox;
    logic       pa_enable;
    logic       tr_disable;
    logic       vna;
    last_chan_t last_chan;
  } radio_state_t;

endpackage

//--- hw/hl_cmd_if.sv
// command channel between frame decoder and register executor
// four-phase req/ack handshake
interface cmd_if;
  import hl_proto_pkg::*;

  // handshake pair
  logic      req;
  logic      ack;

  // fields, held while req is high
  logic      resp_rqst;
  logic      mox;
  cmd_addr_t addr;
  cmd_data_t data;

  // decoder issues the command
  modport decoder (
    output req,
    output resp_rqst,
    output mox,
    output addr,
    output data,
    input  ack
  );

  // executor answers with ack
  modport executor (
    input  req,
    input  resp_rqst,
    input  mox,
    input  addr,
    input  data,
    output ack
  );

endinterface

//--- hw/frame_decoder.sv
// host word stream parser with sync search, C&C header capture,
// command issue and I/Q payload routing
module frame_decoder (
  input  logic                   clk_ad9866,
  input  logic                   rst,
  input  logic [15:0]            word_i,
  input  logic                   word_valid_i,
  output logic                   word_ready_o,
  cmd_if.decoder                 cmd,
  output hl_proto_pkg::iq_item_t iq_item_o,
  output logic                   iq_valid_o,
  input  logic                   iq_ready_i
);
  import hl_proto_pkg::*;

  localparam int CNT_W = $clog2(PAYLOAD_WORDS);

  typedef enum logic [2:0] {
    S_SYNC0,
    S_SYNC1,
    S_DATA_HI,
    S_DATA_LO,
    S_PAYLOAD
  } dec_state_t;

  dec_state_t       state;
  logic [CNT_W-1:0] pay_cnt;

  // header fields collected before the command goes out
  logic             hdr_resp;
  logic             hdr_mox;
  cmd_addr_t        hdr_addr;
  logic [15:0]      hdr_data_hi;

  logic             is_iq;
  logic             cmd_busy;
  logic             accept;
  logic             pay_last;

  // ------------------------------------------------------------------------
  // flow control
  // ------------------------------------------------------------------------

  // payload groups are L, R, I, Q so bit 1 marks I/Q positions
  assign is_iq    = (state == S_PAYLOAD) && pay_cnt[1];
  // previous command still in its handshake
  assign cmd_busy = cmd.req | cmd.ack;
  assign pay_last = (pay_cnt == CNT_W'(PAYLOAD_WORDS - 1));

  always_comb begin
    word_ready_o = 1'b1;
    if (is_iq) begin
      word_ready_o = iq_ready_i;
    end else if (state == S_DATA_HI) begin
      // hold the data words until the executor is free
      word_ready_o = ~cmd_busy;
    end
  end

  assign accept = word_valid_i & word_ready_o;

  // audio words are simply not forwarded
  assign iq_valid_o       = word_valid_i & is_iq;
  assign iq_item_o.q      = pay_cnt[0];
  assign iq_item_o.sample = word_i;

  // ------------------------------------------------------------------------
  // frame FSM
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_ad9866) begin
    if (rst) begin
      state   <= S_SYNC0;
      pay_cnt <= '0;
    end else if (accept) begin
      case (state)
        S_SYNC0: begin
          if (word_i == SYNC_WORD) begin
            state <= S_SYNC1;
          end
        end
        S_SYNC1: begin
          // bad sync byte restarts the search
          state <= (word_i[15:8] == SYNC_BYTE) ? S_DATA_HI : S_SYNC0;
        end
        S_DATA_HI: begin
          state <= S_DATA_LO;
        end
        S_DATA_LO: begin
          state   <= S_PAYLOAD;
          pay_cnt <= '0;
        end
        S_PAYLOAD: begin
          if (pay_last) begin
            state <= S_SYNC0;
          end
          pay_cnt <= pay_cnt + 1'b1;
        end
        default: begin
          state <= S_SYNC0;
        end
      endcase
    end
  end

  // header fields captured as their words arrive
  always_ff @(posedge clk_ad9866) begin
    if (accept && (state == S_SYNC1)) begin
      hdr_resp <= word_i[7];
      hdr_addr <= word_i[6:1];
      hdr_mox  <= word_i[0];
    end
    if (accept && (state == S_DATA_HI)) begin
      hdr_data_hi <= word_i;
    end
  end

  // ------------------------------------------------------------------------
  // command issue
  // ------------------------------------------------------------------------

  // fields load together with req so they stay put for the handshake
  always_ff @(posedge clk_ad9866) begin
    if (accept && (state == S_DATA_LO)) begin
      cmd.resp_rqst <= hdr_resp;
      cmd.addr      <= hdr_addr;
      cmd.mox       <= hdr_mox;
      cmd.data      <= {hdr_data_hi, word_i};
    end
  end

  always_ff @(posedge clk_ad9866) begin
    if (rst) begin
      cmd.req <= 1'b0;
    end else if (accept && (state == S_DATA_LO)) begin
      cmd.req <= 1'b1;
    end else if (cmd.req && cmd.ack) begin
      // release once the executor acks
      cmd.req <= 1'b0;
    end
  end

endmodule

//--- hw/stream_fifo.sv
// synchronous valid/ready queue for flat items
module stream_fifo #(
  parameter int DEPTH = 2,
  parameter int WIDTH = 8
) (
  input  logic             clk_ad9866,
  input  logic             rst,
  input  logic [WIDTH-1:0] wr_data_i,
  input  logic             wr_valid_i,
  output logic             wr_ready_o,
  output logic [WIDTH-1:0] rd_data_o,
  output logic             rd_valid_o,
  input  logic             rd_ready_i
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             do_wr;
  logic             do_rd;

  assign wr_ready_o = (count != CW'(DEPTH));
  assign rd_valid_o = (count != '0);
  // head item shows straight from storage
  assign rd_data_o  = mem[rd_ptr];

  assign do_wr = wr_valid_i & wr_ready_o;
  assign do_rd = rd_valid_o & rd_ready_i;

  always_ff @(posedge clk_ad9866) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  // pointers wrap at DEPTH, count tracks occupancy
  always_ff @(posedge clk_ad9866) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- hw/radio_ctrl.sv
// command executor: base registers at address 0 and 9,
// mox, response echo push and ack generation
module radio_ctrl (
  input  logic                       clk_ad9866,
  input  logic                       rst,
  cmd_if.executor                    cmd,
  output hl_proto_pkg::resp_item_t   resp_item_o,
  output logic                       resp_valid_o,
  input  logic                       resp_ready_i,
  output hl_radio_pkg::radio_state_t state_o
);
  import hl_proto_pkg::*;
  import hl_radio_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PUSH,
    ST_DONE
  } exec_state_t;

  exec_state_t  state;
  radio_state_t regs;
  logic         start;

  // first cycle of a new command
  assign start = (state == ST_IDLE) && cmd.req && !cmd.ack;

  // ack high from the end of execution until req drops
  assign cmd.ack = (state == ST_DONE);

  // echo comes from the held command fields
  assign resp_item_o.addr = cmd.addr;
  assign resp_item_o.data = cmd.data;
  assign resp_valid_o     = (state == ST_PUSH);

  assign state_o = regs;

  // ------------------------------------------------------------------------
  // handshake FSM
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_ad9866) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= cmd.resp_rqst ? ST_PUSH : ST_DONE;
          end
        end
        ST_PUSH: begin
          // wait here while the response queue is full
          if (resp_ready_i) begin
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (!cmd.req) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // base registers
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_ad9866) begin
    if (rst) begin
      regs <= '0;
    end else if (start) begin
      // every frame carries mox
      regs.mox <= cmd.mox;
      if (cmd.addr == ADDR_RX_CTRL) begin
        regs.last_chan <= cmd.data[LAST_CHAN_LSB +: $bits(last_chan_t)];
      end
      if (cmd.addr == ADDR_PA_CTRL) begin
        regs.vna        <= cmd.data[VNA_BIT];
        regs.pa_enable  <= cmd.data[PA_EN_BIT];
        regs.tr_disable <= cmd.data[TR_DIS_BIT];
      end
    end
  end

endmodule

//--- hw/tx_keying.sv
// ptt and tx inhibit debouncers,
// registered PTT, PA T/R, PA enable and RF switch outputs
module tx_keying #(
  parameter int DEBOUNCE_CYCLES = 16
) (
  input  logic                       clk_ad9866,
  input  logic                       rst,
  input  hl_radio_pkg::radio_state_t state_i,
  input  logic                       ptt_n_i,
  input  logic                       txinhibit_n_i,
  output logic                       ptt_o,
  output logic                       pa_tr_o,
  output logic                       pa_en_o,
  output logic                       rfsw_sel_o
);

  localparam int DW = $clog2(DEBOUNCE_CYCLES + 1);

  // index 0 is ptt, index 1 is tx inhibit, both active high here
  logic [1:0]    raw_q;
  logic [1:0]    clean;
  logic [DW-1:0] db_cnt [2];
  logic          ptt_next;

  // sample the pins once
  always_ff @(posedge clk_ad9866) begin
    if (rst) begin
      raw_q <= 2'b00;
    end else begin
      raw_q <= {~txinhibit_n_i, ~ptt_n_i};
    end
  end

  // ------------------------------------------------------------------------
  // debounce counters
  // ------------------------------------------------------------------------

  for (genvar i = 0; i < 2; i++) begin : g_db
    always_ff @(posedge clk_ad9866) begin
      if (rst) begin
        clean[i]  <= 1'b0;
        db_cnt[i] <= '0;
      end else if (raw_q[i] == clean[i]) begin
        // any bounce back restarts the count
        db_cnt[i] <= '0;
      end else if (db_cnt[i] == DW'(DEBOUNCE_CYCLES - 1)) begin
        clean[i]  <= raw_q[i];
        db_cnt[i] <= '0;
      end else begin
        db_cnt[i] <= db_cnt[i] + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // keying outputs
  // ------------------------------------------------------------------------

  // inhibit overrides both mox and the ptt pin
  assign ptt_next = (state_i.mox | clean[0]) & ~clean[1];

  always_ff @(posedge clk_ad9866) begin
    if (rst) begin
      ptt_o      <= 1'b0;
      pa_tr_o    <= 1'b0;
      pa_en_o    <= 1'b0;
      rfsw_sel_o <= 1'b0;
    end else begin
      ptt_o      <= ptt_next;
      // T/R relay follows ptt unless disabled with the PA off
      pa_tr_o    <= ptt_next & (state_i.pa_enable | ~state_i.tr_disable);
      pa_en_o    <= ptt_next & state_i.pa_enable;
      rfsw_sel_o <= state_i.pa_enable;
    end
  end

endmodule

//--- hw/hl_cmd_top.sv
// host command path top: decoder, I/Q and response queues,
// register executor and tx keying
module hl_cmd_top #(
  parameter int IQ_DEPTH        = 256,
  parameter int RESP_DEPTH      = 2,
  parameter int DEBOUNCE_CYCLES = 384000
) (
  input  logic                     clk_ad9866,
  input  logic                     rst,
  // host word stream
  input  logic [15:0]              word_i,
  input  logic                     word_valid_i,
  output logic                     word_ready_o,
  // tx samples
  output hl_proto_pkg::iq_item_t   iq_item_o,
  output logic                     iq_valid_o,
  input  logic                     iq_ready_i,
  // command echoes
  output hl_proto_pkg::resp_item_t resp_item_o,
  output logic                     resp_valid_o,
  input  logic                     resp_ready_i,
  // keying
  input  logic                     ptt_n_i,
  input  logic                     txinhibit_n_i,
  output logic                     ptt_o,
  output logic                     pa_tr_o,
  output logic                     pa_en_o,
  output logic                     rfsw_sel_o,
  // register readback
  output hl_radio_pkg::last_chan_t last_chan_o,
  output logic                     vna_o
);
  import hl_proto_pkg::*;
  import hl_radio_pkg::*;

  iq_item_t     dec_iq_item;
  logic         dec_iq_valid;
  logic         dec_iq_ready;
  resp_item_t   exe_resp_item;
  logic         exe_resp_valid;
  logic         exe_resp_ready;
  radio_state_t radio_state;

  cmd_if cmd0 ();

  frame_decoder dec0 (
    .clk_ad9866   (clk_ad9866),
    .rst          (rst),
    .word_i       (word_i),
    .word_valid_i (word_valid_i),
    .word_ready_o (word_ready_o),
    .cmd          (cmd0.decoder),
    .iq_item_o    (dec_iq_item),
    .iq_valid_o   (dec_iq_valid),
    .iq_ready_i   (dec_iq_ready)
  );

  stream_fifo #(.DEPTH(IQ_DEPTH), .WIDTH($bits(iq_item_t))) iq_fifo0 (
    .clk_ad9866 (clk_ad9866),
    .rst        (rst),
    .wr_data_i  (dec_iq_item),
    .wr_valid_i (dec_iq_valid),
    .wr_ready_o (dec_iq_ready),
    .rd_data_o  (iq_item_o),
    .rd_valid_o (iq_valid_o),
    .rd_ready_i (iq_ready_i)
  );

  radio_ctrl exe0 (
    .clk_ad9866   (clk_ad9866),
    .rst          (rst),
    .cmd          (cmd0.executor),
    .resp_item_o  (exe_resp_item),
    .resp_valid_o (exe_resp_valid),
    .resp_ready_i (exe_resp_ready),
    .state_o      (radio_state)
  );

  stream_fifo #(.DEPTH(RESP_DEPTH), .WIDTH($bits(resp_item_t))) resp_fifo0 (
    .clk_ad9866 (clk_ad9866),
    .rst        (rst),
    .wr_data_i  (exe_resp_item),
    .wr_valid_i (exe_resp_valid),
    .wr_ready_o (exe_resp_ready),
    .rd_data_o  (resp_item_o),
    .rd_valid_o (resp_valid_o),
    .rd_ready_i (resp_ready_i)
  );

  tx_keying #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) key0 (
    .clk_ad9866    (clk_ad9866),
    .rst           (rst),
    .state_i       (radio_state),
    .ptt_n_i       (ptt_n_i),
    .txinhibit_n_i (txinhibit_n_i),
    .ptt_o         (ptt_o),
    .pa_tr_o       (pa_tr_o),
    .pa_en_o       (pa_en_o),
    .rfsw_sel_o    (rfsw_sel_o)
  );

  // register readback straight from executor state
  assign last_chan_o = radio_state.last_chan;
  assign vna_o       = radio_state.vna;

endmodule

//--- sim/tb_checker.sv
// reference model of the host frame format, expected I/Q and response
// queues, register readback and keying comparisons
module tb_checker #(
  parameter int DEBOUNCE_CYCLES = 16
) (
  input  logic        clk_ad9866,
  input  logic        rst,
  input  logic [15:0] word_i,
  input  logic        word_valid_i,
  input  logic        word_ready_i,
  input  logic [16:0] iq_item_i,
  input  logic        iq_valid_i,
  input  logic        iq_ready_i,
  input  logic [37:0] resp_item_i,
  input  logic        resp_valid_i,
  input  logic        resp_ready_i,
  input  logic        ptt_n_i,
  input  logic        txinhibit_n_i,
  input  logic        ptt_i,
  input  logic        pa_tr_i,
  input  logic        pa_en_i,
  input  logic        rfsw_sel_i,
  input  logic [4:0]  last_chan_i,
  input  logic        vna_i,
  output int          err_cnt_o,
  output int          iq_cnt_o,
  output int          resp_cnt_o,
  output int          pending_o
);

  localparam logic [15:0] SYNC_WORD     = 16'h7F7F;
  localparam logic [7:0]  SYNC_BYTE     = 8'h7F;
  localparam int          PAYLOAD_WORDS = 252;
  localparam int          KEY_SETTLE    = DEBOUNCE_CYCLES + 4;

  // 0 sync word, 1 sync byte and C&C, 2 data high, 3 data low, 4 payload
  int          phase;
  int          pay_idx;
  int          stable_cnt;
  int          rst_cycles;
  logic        h_resp;
  logic        h_mox;
  logic [5:0]  h_addr;
  logic [31:0] h_data;
  logic        exp_mox;
  logic        exp_pa_en;
  logic        exp_tr_dis;
  logic        exp_vna;
  logic [4:0]  exp_last_chan;
  logic        exp_ptt;
  logic [4:0]  key_now;
  logic [4:0]  key_last;
  logic [16:0] iq_q [$];
  logic [37:0] resp_q [$];

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] want);
    if (got !== want) begin
      err_cnt_o++;
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, want);
    end
  endtask

  // ------------------------------------------------------------------------
  // frame model
  // ------------------------------------------------------------------------

  // register effects of one command, echo queued on request
  task automatic run_command();
    exp_mox = h_mox;
    if (h_addr == 6'd0) begin
      exp_last_chan = h_data[7:3];
    end
    if (h_addr == 6'd9) begin
      exp_vna    = h_data[23];
      exp_pa_en  = h_data[19];
      exp_tr_dis = h_data[18];
    end
    if (h_resp) begin
      resp_q.push_back({h_addr, h_data});
    end
  endtask

  task automatic take_word(input logic [15:0] w);
    case (phase)
      0: begin
        if (w == SYNC_WORD) begin
          phase = 1;
        end
      end
      1: begin
        if (w[15:8] == SYNC_BYTE) begin
          h_resp = w[7];
          h_addr = w[6:1];
          h_mox  = w[0];
          phase  = 2;
        end else begin
          phase = 0;
        end
      end
      2: begin
        h_data[31:16] = w;
        phase         = 3;
      end
      3: begin
        h_data[15:0] = w;
        run_command();
        pay_idx = 0;
        phase   = 4;
      end
      default: begin
        // groups of L, R, I, Q with audio dropped
        if (pay_idx % 4 == 2) begin
          iq_q.push_back({1'b0, w});
        end else if (pay_idx % 4 == 3) begin
          iq_q.push_back({1'b1, w});
        end
        pay_idx++;
        if (pay_idx == PAYLOAD_WORDS) begin
          check_val("last_chan_o", 64'(last_chan_i), 64'(exp_last_chan));
          check_val("vna_o", 64'(vna_i), 64'(exp_vna));
          phase = 0;
        end
      end
    endcase
  endtask

  // ------------------------------------------------------------------------
  // output comparisons
  // ------------------------------------------------------------------------

  task automatic pop_iq();
    logic [16:0] want;
    if (iq_q.size() == 0) begin
      err_cnt_o++;
      $display("I/Q item at %0t with no item left in the model", $time);
    end else begin
      want = iq_q.pop_front();
      check_val("iq_item_o", 64'(iq_item_i), 64'(want));
      iq_cnt_o++;
    end
  endtask

  task automatic pop_resp();
    logic [37:0] want;
    if (resp_q.size() == 0) begin
      err_cnt_o++;
      $display("response at %0t that no frame asked for", $time);
    end else begin
      want = resp_q.pop_front();
      check_val("resp_item_o", 64'(resp_item_i), 64'(want));
      resp_cnt_o++;
    end
  endtask

  // compare only once pins and register fields have settled
  task automatic check_keying();
    key_now = {ptt_n_i, txinhibit_n_i, exp_mox, exp_pa_en, exp_tr_dis};
    if (key_now != key_last) begin
      stable_cnt = 0;
    end else if (stable_cnt < KEY_SETTLE) begin
      stable_cnt++;
    end
    key_last = key_now;
    if (stable_cnt >= KEY_SETTLE) begin
      // inhibit wins over mox and the ptt pin
      exp_ptt = (exp_mox | ~ptt_n_i) & txinhibit_n_i;
      check_val("ptt_o", 64'(ptt_i), 64'(exp_ptt));
      check_val("pa_tr_o", 64'(pa_tr_i), 64'(exp_ptt & (exp_pa_en | ~exp_tr_dis)));
      check_val("pa_en_o", 64'(pa_en_i), 64'(exp_ptt & exp_pa_en));
      check_val("rfsw_sel_o", 64'(rfsw_sel_i), 64'(exp_pa_en));
    end
  endtask

  task automatic check_reset_values();
    check_val("word_ready_o", 64'(word_ready_i), 64'd1);
    check_val("iq_valid_o", 64'(iq_valid_i), 64'd0);
    check_val("resp_valid_o", 64'(resp_valid_i), 64'd0);
    check_val("ptt_o", 64'(ptt_i), 64'd0);
    check_val("pa_tr_o", 64'(pa_tr_i), 64'd0);
    check_val("pa_en_o", 64'(pa_en_i), 64'd0);
    check_val("rfsw_sel_o", 64'(rfsw_sel_i), 64'd0);
    check_val("vna_o", 64'(vna_i), 64'd0);
    check_val("last_chan_o", 64'(last_chan_i), 64'd0);
  endtask

  // pre-edge values, inputs were driven on the falling edge
  always @(posedge clk_ad9866) begin
    if (rst) begin
      rst_cycles++;
      if (rst_cycles > 2) begin
        check_reset_values();
      end
      phase         = 0;
      pay_idx       = 0;
      stable_cnt    = 0;
      exp_mox       = 1'b0;
      exp_pa_en     = 1'b0;
      exp_tr_dis    = 1'b0;
      exp_vna       = 1'b0;
      exp_last_chan = 5'd0;
      key_last      = 5'd0;
      iq_q.delete();
      resp_q.delete();
    end else begin
      if (word_valid_i && word_ready_i) begin
        take_word(word_i);
      end
      if (iq_valid_i && iq_ready_i) begin
        pop_iq();
      end
      if (resp_valid_i && resp_ready_i) begin
        pop_resp();
      end
      check_keying();
    end
    pending_o = iq_q.size() + resp_q.size();
  end

endmodule

//--- sim/tb_top.sv
// testbench top with clock, reset, LCG frame stimulus under back-pressure,
// watchdog and closing report
module tb_top;

  localparam int CLK_PERIOD      = 20;
  localparam int NUM_FRAMES      = 40;
  localparam int FRAME_WORDS     = 256;
  localparam int PAYLOAD_WORDS   = 252;
  localparam int IQ_PER_FRAME    = 126;
  localparam int DEBOUNCE_CYCLES = 16;
  // four cycles per word for gaps and slow I/Q drain plus an end margin
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_WORDS * 4 + 4000;

  logic        clk_ad9866 = 1'b0;
  logic        rst;
  logic [15:0] word_i;
  logic        word_valid_i;
  logic        word_ready_o;
  logic [16:0] iq_item_o;
  logic        iq_valid_o;
  logic        iq_ready_i;
  logic [37:0] resp_item_o;
  logic        resp_valid_o;
  logic        resp_ready_i;
  logic        ptt_n_i;
  logic        txinhibit_n_i;
  logic        ptt_o;
  logic        pa_tr_o;
  logic        pa_en_o;
  logic        rfsw_sel_o;
  logic [4:0]  last_chan_o;
  logic        vna_o;

  logic [31:0] lcg_state;
  // mostly stalled I/Q consumer fills the queue over several frames
  logic        iq_slow;
  int          good_frames;
  int          resp_frames;
  int          tb_errors;
  int          chk_errors;
  int          chk_iq;
  int          chk_resp;
  int          chk_pending;

  always #(CLK_PERIOD / 2) clk_ad9866 = ~clk_ad9866;

  hl_cmd_top #(
    .IQ_DEPTH        (256),
    .RESP_DEPTH      (2),
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) dut0 (
    .clk_ad9866    (clk_ad9866),
    .rst           (rst),
    .word_i        (word_i),
    .word_valid_i  (word_valid_i),
    .word_ready_o  (word_ready_o),
    .iq_item_o     (iq_item_o),
    .iq_valid_o    (iq_valid_o),
    .iq_ready_i    (iq_ready_i),
    .resp_item_o   (resp_item_o),
    .resp_valid_o  (resp_valid_o),
    .resp_ready_i  (resp_ready_i),
    .ptt_n_i       (ptt_n_i),
    .txinhibit_n_i (txinhibit_n_i),
    .ptt_o         (ptt_o),
    .pa_tr_o       (pa_tr_o),
    .pa_en_o       (pa_en_o),
    .rfsw_sel_o    (rfsw_sel_o),
    .last_chan_o   (last_chan_o),
    .vna_o         (vna_o)
  );

  tb_checker #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) chk0 (
    .clk_ad9866    (clk_ad9866),
    .rst           (rst),
    .word_i        (word_i),
    .word_valid_i  (word_valid_i),
    .word_ready_i  (word_ready_o),
    .iq_item_i     (iq_item_o),
    .iq_valid_i    (iq_valid_o),
    .iq_ready_i    (iq_ready_i),
    .resp_item_i   (resp_item_o),
    .resp_valid_i  (resp_valid_o),
    .resp_ready_i  (resp_ready_i),
    .ptt_n_i       (ptt_n_i),
    .txinhibit_n_i (txinhibit_n_i),
    .ptt_i         (ptt_o),
    .pa_tr_i       (pa_tr_o),
    .pa_en_i       (pa_en_o),
    .rfsw_sel_i    (rfsw_sel_o),
    .last_chan_i   (last_chan_o),
    .vna_i         (vna_o),
    .err_cnt_o     (chk_errors),
    .iq_cnt_o      (chk_iq),
    .resp_cnt_o    (chk_resp),
    .pending_o     (chk_pending)
  );

  // ------------------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // filler in bad frames must never look like a sync word
  function automatic logic [15:0] no_sync(input logic [15:0] w);
    return (w == 16'h7F7F) ? 16'h0000 : w;
  endfunction

  // drive one host word with random gaps until it is accepted
  task automatic send_word(input logic [15:0] w);
    logic [31:0] r;
    bit          taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk_ad9866);
      r            = lcg_next();
      word_i       = w;
      word_valid_i = (r[17:16] != 2'b00);
      iq_ready_i   = iq_slow ? (r[19:18] == 2'b00) : (r[19:18] != 2'b00);
      resp_ready_i = r[20];
      @(posedge clk_ad9866);
      taken = word_valid_i && word_ready_o;
    end
  endtask

  task automatic send_frame(input int idx);
    logic [31:0] r;
    logic [31:0] data;
    logic [5:0]  addr;
    logic [15:0] cc_word;
    bit          bad0;
    bit          bad1;
    bit          bad;
    r    = lcg_next();
    data = lcg_next();
    // mostly the two base registers
    case (r[1:0])
      2'd0:    addr = 6'd0;
      2'd1:    addr = 6'd9;
      default: addr = r[7:2];
    endcase
    cc_word = {8'h7F, r[8], addr, r[9]};
    bad0    = (idx == 2) || (r[15:12] == 4'h0);
    bad1    = (idx == 3) || (r[15:12] == 4'h1);
    bad     = bad0 || bad1;
    iq_slow = idx[3];
    if (bad1) begin
      cc_word[15:8] = 8'h3F;
    end
    // slow key levels change at most once per frame
    @(negedge clk_ad9866);
    word_valid_i  = 1'b0;
    ptt_n_i       = (r[17:16] != 2'b00);
    txinhibit_n_i = (r[22:20] != 3'd0);
    send_word(bad0 ? 16'h7F3F : 16'h7F7F);
    send_word(bad0 ? no_sync(cc_word) : cc_word);
    send_word(bad ? no_sync(data[31:16]) : data[31:16]);
    send_word(bad ? no_sync(data[15:0]) : data[15:0]);
    for (int i = 0; i < PAYLOAD_WORDS; i++) begin
      r = lcg_next();
      send_word(bad ? no_sync(r[31:16]) : r[31:16]);
    end
    if (!bad) begin
      good_frames++;
      if (cc_word[7]) begin
        resp_frames++;
      end
    end
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------

  initial begin
    lcg_state     = 32'h4931_2b2d;
    rst           = 1'b1;
    word_i        = 16'h0000;
    word_valid_i  = 1'b0;
    iq_ready_i    = 1'b0;
    resp_ready_i  = 1'b0;
    ptt_n_i       = 1'b1;
    txinhibit_n_i = 1'b1;
    iq_slow       = 1'b0;
    good_frames   = 0;
    resp_frames   = 0;
    tb_errors     = 0;
    repeat (10) @(negedge clk_ad9866);
    rst = 1'b0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      send_frame(f);
    end
    // drain both queues and let keying settle for the last checks
    @(negedge clk_ad9866);
    word_valid_i = 1'b0;
    iq_ready_i   = 1'b1;
    resp_ready_i = 1'b1;
    while (chk_pending != 0) begin
      @(negedge clk_ad9866);
    end
    repeat (DEBOUNCE_CYCLES + 8) @(negedge clk_ad9866);
    if (chk_iq != good_frames * IQ_PER_FRAME) begin
      tb_errors++;
      $display("I/Q item total %0d does not match %0d good frames", chk_iq, good_frames);
    end
    if (chk_resp != resp_frames) begin
      tb_errors++;
      $display("response total %0d does not match %0d requests", chk_resp, resp_frames);
    end
    $display("errors: checker %0d, testbench %0d; iq %0d, resp %0d, good frames %0d of %0d",
             chk_errors, tb_errors, chk_iq, chk_resp, good_frames, NUM_FRAMES);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_ad9866);
    $display("timeout: run not finished after %0d cycles", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- sim.f
hw/hl_proto_pkg.sv
hw/hl_radio_pkg.sv
hw/hl_cmd_if.sv
hw/frame_decoder.sv
hw/stream_fifo.sv
hw/radio_ctrl.sv
hw/tx_keying.sv
hw/hl_cmd_top.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- Makefile
# Verilator build and run of the host command path testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_LINE ?= >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx '$(PASS_LINE)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
